//--- all.f
src/mipsPkg.sv
src/mainDecoder.sv
src/hazardUnit.sv
src/regFile.sv
src/alu.sv
src/branchUnit.sv
src/memAlign.sv
src/mipsDatapath.sv
src/mipsCore.sv
dv/tbMipsCore.sv

//--- dv/tbMipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module tbMipsCore;

    logic        clk  = 1'b0;
    logic        rstN = 1'b0;
    logic [31:0] pc, instr, memAddr, memWriteData, memReadData;
    logic        instrEn, memEn;
    logic [3:0]  memByteEn;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    // one row per test: program, then the marker store it must end with
    logic [31:0] prog [6][12];
    logic [31:0] expAddr [6];
    logic [31:0] expData [6];
    logic [3:0]  expBe [6];
    string       testName [6];

    int errors     = 0;
    int passCount  = 0;
    int failCount  = 0;
    int cycleCount = 0;
    int cycleLimit = 6 * 60;  // rows times 60 cycles

    always #2 clk = ~clk;

    mipsCore uut (
        .clk(clk), .rstN(rstN), .pc(pc), .instrEn(instrEn), .instr(instr),
        .memAddr(memAddr), .memWriteData(memWriteData), .memEn(memEn),
        .memByteEn(memByteEn), .memReadData(memReadData)
    );

    assign instr       = imem[pc[9:2]];
    assign memReadData = dmem[memAddr[9:2]];

    // data memory, cleared while reset is held
    always @(posedge clk) begin
        if (!rstN) begin
            foreach (dmem[i])
                dmem[i] <= 32'h0;
        end else begin
            for (int i = 0; i < 4; i++)
                if (memByteEn[i])
                    dmem[memAddr[9:2]][8*i +: 8] <= memWriteData[8*i +: 8];
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: no result store seen within %0d cycles", cycleLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] rInstr(input logic [5:0] fn, input int rs, input int rt,
                                            input int rd, input int sh);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [31:0] iInstr(input logic [5:0] op, input int rs, input int rt,
                                            input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] jInstr(input logic [5:0] op, input int wordIndex);
        return {op, wordIndex[25:0]};
    endfunction

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic setExpect(input int row, input string name, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] be);
        testName[row] = name;
        expAddr[row]  = addr;
        expData[row]  = data;
        expBe[row]    = be;
    endtask

    task automatic fillTable();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom();
        b = $urandom();
        // r1=5 r2=-3, r3=8 r4=0x80, r5=1 r6=0x12340000, or/xor, r7=-2, sum into r6
        prog[0] = '{
            iInstr(mipsPkg::opAddiu, 0, 1, 5), iInstr(mipsPkg::opAddiu, 0, 2, -3),
            rInstr(mipsPkg::fnSubu, 1, 2, 3, 0), rInstr(mipsPkg::fnSll, 0, 3, 4, 4),
            rInstr(mipsPkg::fnSlt, 2, 1, 5, 0), iInstr(mipsPkg::opLui, 0, 6, 'h1234),
            rInstr(mipsPkg::fnOr, 6, 4, 6, 0), rInstr(mipsPkg::fnXor, 6, 5, 6, 0),
            rInstr(mipsPkg::fnSra, 0, 2, 7, 1), rInstr(mipsPkg::fnAddu, 6, 7, 6, 0),
            iInstr(mipsPkg::opSw, 0, 6, 'h200), jInstr(mipsPkg::opJ, 11)
        };
        setExpect(0, "alu", 'h200, 'h1234007f, 4'hf);
        // addiu right behind the lw, final sb lands in lane 2
        prog[1] = '{
            iInstr(mipsPkg::opAddiu, 0, 1, 'h55), iInstr(mipsPkg::opSw, 0, 1, 'h100),
            iInstr(mipsPkg::opLw, 0, 2, 'h100), iInstr(mipsPkg::opAddiu, 2, 3, 1),
            rInstr(mipsPkg::fnAddu, 3, 2, 4, 0), iInstr(mipsPkg::opSb, 0, 4, 'h202),
            jInstr(mipsPkg::opJ, 6), 32'h0, 32'h0, 32'h0, 32'h0, 32'h0
        };
        setExpect(1, "load-use", 'h200, 'habababab, 4'b0100);
        // word 0x11223344, byte 0x80 into lane 1, then lb/lbu/lw back
        prog[2] = '{
            iInstr(mipsPkg::opAddiu, 0, 1, 'h80), iInstr(mipsPkg::opLui, 0, 2, 'h1122),
            iInstr(mipsPkg::opOri, 2, 2, 'h3344), iInstr(mipsPkg::opSw, 0, 2, 'h100),
            iInstr(mipsPkg::opSb, 0, 1, 'h101), iInstr(mipsPkg::opLb, 0, 3, 'h101),
            iInstr(mipsPkg::opLbu, 0, 4, 'h101), iInstr(mipsPkg::opLw, 0, 5, 'h100),
            rInstr(mipsPkg::fnXor, 3, 4, 6, 0), rInstr(mipsPkg::fnAddu, 6, 5, 6, 0),
            iInstr(mipsPkg::opSw, 0, 6, 'h200), jInstr(mipsPkg::opJ, 11)
        };
        setExpect(2, "byte access", 'h200, 'h11227f44, 4'hf);
        // beq taken to word 6, bne falls through, words 4/5/10 must not run
        prog[3] = '{
            iInstr(mipsPkg::opAddiu, 0, 3, 1), iInstr(mipsPkg::opAddiu, 0, 1, 7),
            iInstr(mipsPkg::opAddiu, 0, 2, 7), iInstr(mipsPkg::opBeq, 1, 2, 2),
            iInstr(mipsPkg::opAddiu, 0, 3, 'h99), iInstr(mipsPkg::opAddiu, 0, 3, 'h77),
            iInstr(mipsPkg::opBne, 1, 2, 3), iInstr(mipsPkg::opAddiu, 3, 3, 'h10),
            iInstr(mipsPkg::opSw, 0, 3, 'h200), jInstr(mipsPkg::opJ, 9),
            iInstr(mipsPkg::opSw, 0, 0, 'h200), jInstr(mipsPkg::opJ, 11)
        };
        setExpect(3, "branch", 'h200, 'h00000011, 4'hf);
        // j over word 2, jal to word 7 links 16, jr back to word 4
        prog[4] = '{
            iInstr(mipsPkg::opAddiu, 0, 1, 'h20), jInstr(mipsPkg::opJ, 3),
            iInstr(mipsPkg::opAddiu, 0, 1, 'h66), jInstr(mipsPkg::opJal, 7),
            rInstr(mipsPkg::fnAddu, 1, 31, 2, 0), iInstr(mipsPkg::opSw, 0, 2, 'h200),
            jInstr(mipsPkg::opJ, 6), iInstr(mipsPkg::opAddiu, 1, 1, 'h100),
            rInstr(mipsPkg::fnJr, 31, 0, 0, 0), iInstr(mipsPkg::opAddiu, 0, 1, 'h55),
            32'h0, 32'h0
        };
        setExpect(4, "jump", 'h200, 'h00000130, 4'hf);
        prog[5] = '{
            iInstr(mipsPkg::opLui, 0, 1, int'(a[31:16])),
            iInstr(mipsPkg::opOri, 1, 1, int'(a[15:0])),
            iInstr(mipsPkg::opLui, 0, 2, int'(b[31:16])),
            iInstr(mipsPkg::opOri, 2, 2, int'(b[15:0])),
            rInstr(mipsPkg::fnAddu, 1, 2, 3, 0), rInstr(mipsPkg::fnXor, 3, 1, 4, 0),
            iInstr(mipsPkg::opSw, 0, 4, 'h204), jInstr(mipsPkg::opJ, 7),
            32'h0, 32'h0, 32'h0, 32'h0
        };
        setExpect(5, "random operands", 'h204, (a + b) ^ a, 4'hf);
    endtask

    initial begin
        int waited;
        int errorsBefore;
        void'($urandom(32'h8032));
        fillTable();
        for (int r = 0; r < 6; r++) begin
            @(negedge clk);
            rstN = 1'b0;
            foreach (imem[i])
                imem[i] = 32'h0;
            for (int i = 0; i < 12; i++)
                imem[i] = prog[r][i];
            errorsBefore = errors;
            repeat (5) begin
                @(negedge clk);
                checkEq("memEn in reset", 32'(memEn), 0);
                checkEq("memByteEn in reset", 32'(memByteEn), 0);
            end
            checkEq("pc after reset", pc, 0);
            checkEq("instrEn after reset", 32'(instrEn), 1);
            rstN  = 1'b1;
            waited = 0;
            // first word reaches memory on the third edge
            do begin
                @(negedge clk);
                waited++;
                if (waited < 3) begin
                    checkEq("memEn before first store", 32'(memEn), 0);
                    checkEq("memByteEn before first store", 32'(memByteEn), 0);
                end
            end while (!(memByteEn != 4'b0000 && memAddr >= 32'h200));
            checkEq("store address", memAddr, expAddr[r]);
            checkEq("store data", memWriteData, expData[r]);
            checkEq("store byte enables", 32'(memByteEn), 32'(expBe[r]));
            if (errors == errorsBefore) begin
                passCount++;
                $display("test %0d %s: ok", r, testName[r]);
            end else begin
                failCount++;
                $display("test %0d %s: mismatch", r, testName[r]);
            end
        end
        $display("%0d tests ok, %0d with errors", passCount, failCount);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tbMipsCore
./obj_dir/VtbMipsCore > sim.log
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0

//--- src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  logic [mipsPkg::dataWidth-1:0] a,
    input  logic [mipsPkg::dataWidth-1:0] b,
    input  logic [4:0]                    shamt,
    input  logic [3:0]                    aluControl,
    output logic [mipsPkg::dataWidth-1:0] result
);

    localparam int zeroPad = mipsPkg::dataWidth - 1;

    always_comb begin
        case (aluControl)
            mipsPkg::aluAdd:  result = a + b;
            mipsPkg::aluSub:  result = a - b;
            mipsPkg::aluAnd:  result = a & b;
            mipsPkg::aluOr:   result = a | b;
            mipsPkg::aluXor:  result = a ^ b;
            mipsPkg::aluNor:  result = ~(a | b);
            mipsPkg::aluSlt:  result = {{zeroPad{1'b0}}, $signed(a) < $signed(b)};
            mipsPkg::aluSltu: result = {{zeroPad{1'b0}}, a < b};
            // shifts act on rt
            mipsPkg::aluSll:  result = b << shamt;
            mipsPkg::aluSrl:  result = b >> shamt;
            mipsPkg::aluSra:  result = $signed(b) >>> shamt;
            mipsPkg::aluLui:  result = {b[15:0], 16'h0000};
            default:          result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/branchUnit.sv
`timescale 1ns/100ps
`default_nettype none

module branchUnit (
    input  logic [5:0]                    opcode,
    input  logic [5:0]                    funct,
    input  logic                          jumpD,
    input  logic [mipsPkg::dataWidth-1:0] a,
    input  logic [mipsPkg::dataWidth-1:0] b,
    output logic [1:0]                    pcSrc
);

    always_comb begin
        pcSrc = mipsPkg::pcPlus4;
        if (jumpD)
            pcSrc = (opcode == mipsPkg::opSpecial && funct == mipsPkg::fnJr) ?
                    mipsPkg::pcReg : mipsPkg::pcJump;
        else if (opcode == mipsPkg::opBeq && a == b)
            pcSrc = mipsPkg::pcBranch;
        else if (opcode == mipsPkg::opBne && a != b)
            pcSrc = mipsPkg::pcBranch;
    end

endmodule

`default_nettype wire

//--- src/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
    input  logic [mipsPkg::regAddrWidth-1:0] rsD, rtD, rsE, rtE,
    input  logic [mipsPkg::regAddrWidth-1:0] writeRegE, writeRegM, writeRegW,
    input  logic                             regWriteE, regWriteM, regWriteW,
    input  logic                             memToRegE, memToRegM,
    input  logic                             branchD,
    output logic [mipsPkg::hazWidth-1:0]     hazardControl
);

    logic loadStall;
    logic branchStall;
    logic stall;

    // nonzero source produced by a writing stage
    function automatic logic hit(input logic [4:0] src, input logic [4:0] dst,
                                 input logic en);
        return en && (src != 5'd0) && (src == dst);
    endfunction

    assign loadStall = hit(rsD, writeRegE, memToRegE) || hit(rtD, writeRegE, memToRegE);

    // decode compare needs the operand now, memory result only after the load leaves
    assign branchStall = branchD && (hit(rsD, writeRegE, regWriteE) ||
                                     hit(rtD, writeRegE, regWriteE) ||
                                     hit(rsD, writeRegM, memToRegM) ||
                                     hit(rtD, writeRegM, memToRegM));
    assign stall = loadStall || branchStall;

    always_comb begin
        hazardControl = '0;
        if (hit(rsE, writeRegM, regWriteM))
            hazardControl[mipsPkg::hazForwardA +: 2] = mipsPkg::fwdMem;
        else if (hit(rsE, writeRegW, regWriteW))
            hazardControl[mipsPkg::hazForwardA +: 2] = mipsPkg::fwdWb;
        if (hit(rtE, writeRegM, regWriteM))
            hazardControl[mipsPkg::hazForwardB +: 2] = mipsPkg::fwdMem;
        else if (hit(rtE, writeRegW, regWriteW))
            hazardControl[mipsPkg::hazForwardB +: 2] = mipsPkg::fwdWb;
        hazardControl[mipsPkg::hazForwardAD] = hit(rsD, writeRegM, regWriteM);
        hazardControl[mipsPkg::hazForwardBD] = hit(rtD, writeRegM, regWriteM);
        hazardControl[mipsPkg::hazStallF]    = stall;
        hazardControl[mipsPkg::hazStallD]    = stall;
        hazardControl[mipsPkg::hazFlushE]    = stall;  // bubble into execute
    end

endmodule

`default_nettype wire

//--- src/mainDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module mainDecoder (
    input  logic [mipsPkg::dataWidth-1:0] instr,
    output logic [mipsPkg::ctrlWidth-1:0] mainControl,
    output logic [3:0]                    aluControl
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        mainControl = '0;
        aluControl  = mipsPkg::aluAdd;
        case (opcode)
            mipsPkg::opSpecial: begin
                mainControl[mipsPkg::ctrlRegWrite]      = 1'b1;
                mainControl[mipsPkg::ctrlRegDst +: 2]   = 2'd1;  // rd
                case (funct)
                    mipsPkg::fnAddu: aluControl = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: aluControl = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  aluControl = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   aluControl = mipsPkg::aluOr;
                    mipsPkg::fnXor:  aluControl = mipsPkg::aluXor;
                    mipsPkg::fnNor:  aluControl = mipsPkg::aluNor;
                    mipsPkg::fnSlt:  aluControl = mipsPkg::aluSlt;
                    mipsPkg::fnSltu: aluControl = mipsPkg::aluSltu;
                    mipsPkg::fnSll:  aluControl = mipsPkg::aluSll;
                    mipsPkg::fnSrl:  aluControl = mipsPkg::aluSrl;
                    mipsPkg::fnSra:  aluControl = mipsPkg::aluSra;
                    mipsPkg::fnJr: begin
                        mainControl = '0;
                        mainControl[mipsPkg::ctrlJump] = 1'b1;
                    end
                    default: mainControl = '0;
                endcase
            end
            mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opAndi, mipsPkg::opOri,
            mipsPkg::opXori, mipsPkg::opLui: begin
                mainControl[mipsPkg::ctrlRegWrite]  = 1'b1;
                mainControl[mipsPkg::ctrlAluSrcImm] = 1'b1;
                mainControl[mipsPkg::ctrlZeroExt]   = opcode inside {mipsPkg::opAndi,
                    mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui};
                case (opcode)
                    mipsPkg::opSlti: aluControl = mipsPkg::aluSlt;
                    mipsPkg::opAndi: aluControl = mipsPkg::aluAnd;
                    mipsPkg::opOri:  aluControl = mipsPkg::aluOr;
                    mipsPkg::opXori: aluControl = mipsPkg::aluXor;
                    mipsPkg::opLui:  aluControl = mipsPkg::aluLui;
                    default:         aluControl = mipsPkg::aluAdd;
                endcase
            end
            mipsPkg::opLw, mipsPkg::opLb, mipsPkg::opLbu: begin
                mainControl[mipsPkg::ctrlRegWrite]  = 1'b1;
                mainControl[mipsPkg::ctrlAluSrcImm] = 1'b1;
                mainControl[mipsPkg::ctrlMemToReg]  = 1'b1;
                mainControl[mipsPkg::ctrlMemRead]   = 1'b1;
            end
            mipsPkg::opSw, mipsPkg::opSb: mainControl[mipsPkg::ctrlAluSrcImm] = 1'b1;
            mipsPkg::opBeq, mipsPkg::opBne: mainControl[mipsPkg::ctrlBranch] = 1'b1;
            mipsPkg::opJ: mainControl[mipsPkg::ctrlJump] = 1'b1;
            mipsPkg::opJal: begin
                mainControl[mipsPkg::ctrlJump]        = 1'b1;
                mainControl[mipsPkg::ctrlRegWrite]    = 1'b1;
                mainControl[mipsPkg::ctrlRegDst +: 2] = 2'd2;  // link into r31
                mainControl[mipsPkg::ctrlAluSrcPc]    = 1'b1;
            end
            default: mainControl = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/memAlign.sv
`timescale 1ns/100ps
`default_nettype none

module memAlign (
    input  logic                          clk,
    input  logic [5:0]                    opcode,
    input  logic [mipsPkg::dataWidth-1:0] addr,
    input  logic [mipsPkg::dataWidth-1:0] writeData,
    input  logic [mipsPkg::dataWidth-1:0] readData,
    output logic                          memEn,
    output logic [3:0]                    byteEn,
    output logic [mipsPkg::dataWidth-1:0] alignedAddr,
    output logic [mipsPkg::dataWidth-1:0] alignedWriteData,
    output logic [mipsPkg::dataWidth-1:0] loadData
);

    logic [7:0] lane;

    assign alignedAddr = {addr[31:2], 2'b00};
    assign lane        = readData[{addr[1:0], 3'b000} +: 8];  // lane 0 is bits 7:0

    always_comb begin
        memEn            = 1'b0;
        byteEn           = 4'b0000;
        alignedWriteData = writeData;
        loadData         = readData;
        case (opcode)
            mipsPkg::opLw: memEn = 1'b1;
            mipsPkg::opLb: begin
                memEn    = 1'b1;
                loadData = {{24{lane[7]}}, lane};
            end
            mipsPkg::opLbu: begin
                memEn    = 1'b1;
                loadData = {24'h000000, lane};
            end
            mipsPkg::opSw: begin
                memEn  = 1'b1;
                byteEn = 4'b1111;
            end
            mipsPkg::opSb: begin
                memEn            = 1'b1;
                byteEn           = 4'b0001 << addr[1:0];
                alignedWriteData = {4{writeData[7:0]}};
            end
            default: ;
        endcase
    end

    assert property (@(posedge clk) (byteEn != 4'b0000) |-> memEn);

endmodule

`default_nettype wire

//--- src/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore (
    input  logic        clk,
    input  logic        rstN,
    output logic [31:0] pc,
    output logic        instrEn,
    input  logic [31:0] instr,
    output logic [31:0] memAddr,
    output logic [31:0] memWriteData,
    output logic        memEn,
    output logic [3:0]  memByteEn,
    input  logic [31:0] memReadData
);

    logic [mipsPkg::ctrlWidth-1:0] mainControl;
    logic [3:0]                    aluControl;
    logic [mipsPkg::hazWidth-1:0]  hazardControl;
    logic [31:0]                   instrD;
    logic [4:0] rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW;
    logic regWriteE, regWriteM, regWriteW, memToRegE, memToRegM, branchD;

    mainDecoder decoder (.instr(instrD), .mainControl(mainControl), .aluControl(aluControl));

    hazardUnit hazard (
        .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
        .writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
        .regWriteE(regWriteE), .regWriteM(regWriteM), .regWriteW(regWriteW),
        .memToRegE(memToRegE), .memToRegM(memToRegM), .branchD(branchD),
        .hazardControl(hazardControl)
    );

    mipsDatapath datapath (
        .clk(clk), .rstN(rstN),
        .mainControl(mainControl), .aluControl(aluControl), .hazardControl(hazardControl),
        .instr(instr), .memReadData(memReadData),
        .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
        .writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
        .regWriteE(regWriteE), .regWriteM(regWriteM), .regWriteW(regWriteW),
        .memToRegE(memToRegE), .memToRegM(memToRegM), .branchD(branchD),
        .instrD(instrD), .pc(pc), .instrEn(instrEn),
        .memAddr(memAddr), .memWriteData(memWriteData), .memEn(memEn), .memByteEn(memByteEn)
    );

endmodule

`default_nettype wire

//--- src/mipsDatapath.sv
`timescale 1ns/100ps
`default_nettype none

module mipsDatapath (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [mipsPkg::ctrlWidth-1:0]    mainControl,
    input  logic [3:0]                       aluControl,
    input  logic [mipsPkg::hazWidth-1:0]     hazardControl,
    input  logic [mipsPkg::dataWidth-1:0]    instr,
    input  logic [mipsPkg::dataWidth-1:0]    memReadData,
    output logic [mipsPkg::regAddrWidth-1:0] rsD, rtD, rsE, rtE,
    output logic [mipsPkg::regAddrWidth-1:0] writeRegE, writeRegM, writeRegW,
    output logic                             regWriteE, regWriteM, regWriteW,
    output logic                             memToRegE, memToRegM,
    output logic                             branchD,
    output logic [mipsPkg::dataWidth-1:0]    instrD,
    output logic [mipsPkg::dataWidth-1:0]    pc,
    output logic                             instrEn,
    output logic [mipsPkg::dataWidth-1:0]    memAddr,
    output logic [mipsPkg::dataWidth-1:0]    memWriteData,
    output logic                             memEn,
    output logic [3:0]                       memByteEn
);

    logic stallF, stallD, flushE, forwardAD, forwardBD, flushD;
    logic [1:0] forwardAE, forwardBE, pcSrcD;
    logic [mipsPkg::ctrlWidth-1:0] ctrlE, ctrlM, ctrlW;
    logic [3:0] aluOpE;
    logic [5:0] opcodeE, opcodeM;
    logic [4:0] rdE, shamtE;
    logic [31:0] pcNext, pcPlus4F, pcPlus4D, pcPlus4E, pcBranchD, pcJumpD;
    logic [31:0] immD, immE, rd1D, rd2D, rd1E, rd2E, cmpAD, cmpBD;
    logic [31:0] fwdAE, fwdBE, srcAE, srcBE, aluOutE;
    logic [31:0] aluOutM, writeDataM, loadDataM, aluOutW, readDataW, resultW;

    assign forwardAE = hazardControl[mipsPkg::hazForwardA +: 2];
    assign forwardBE = hazardControl[mipsPkg::hazForwardB +: 2];
    assign stallF    = hazardControl[mipsPkg::hazStallF];
    assign stallD    = hazardControl[mipsPkg::hazStallD];
    assign flushE    = hazardControl[mipsPkg::hazFlushE];
    assign forwardAD = hazardControl[mipsPkg::hazForwardAD];
    assign forwardBD = hazardControl[mipsPkg::hazForwardBD];

    // fetch
    assign pcPlus4F = pc + 32'd4;
    assign instrEn  = ~stallD;
    always_comb begin
        case (pcSrcD)
            mipsPkg::pcBranch: pcNext = pcBranchD;
            mipsPkg::pcJump:   pcNext = pcJumpD;
            mipsPkg::pcReg:    pcNext = cmpAD;
            default:           pcNext = pcPlus4F;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            pc <= '0;
        else if (!stallF)
            pc <= pcNext;
    end

    // a taken redirect squashes the word now in fetch
    assign flushD = (pcSrcD != mipsPkg::pcPlus4);
    always_ff @(posedge clk) begin
        if (!rstN)
            instrD <= '0;
        else if (!stallD)
            instrD <= flushD ? '0 : instr;
    end

    always_ff @(posedge clk) begin
        if (!stallD)
            pcPlus4D <= pcPlus4F;
    end

    // decode
    assign rsD     = instrD[25:21];
    assign rtD     = instrD[20:16];
    assign branchD = mainControl[mipsPkg::ctrlBranch] |
                     (mainControl[mipsPkg::ctrlJump] & (instrD[31:26] == mipsPkg::opSpecial));
    assign immD = mainControl[mipsPkg::ctrlZeroExt] ? {16'h0000, instrD[15:0]} :
                  {{16{instrD[15]}}, instrD[15:0]};
    assign pcBranchD = pcPlus4D + {immD[29:0], 2'b00};
    assign pcJumpD   = {pcPlus4D[31:28], instrD[25:0], 2'b00};
    assign cmpAD     = forwardAD ? aluOutM : rd1D;
    assign cmpBD     = forwardBD ? aluOutM : rd2D;

    regFile regs (
        .clk(clk), .writeEn(ctrlW[mipsPkg::ctrlRegWrite]),
        .readAddr1(rsD), .readAddr2(rtD), .writeAddr(writeRegW), .writeData(resultW),
        .readData1(rd1D), .readData2(rd2D)
    );

    branchUnit branch (
        .opcode(instrD[31:26]), .funct(instrD[5:0]), .jumpD(mainControl[mipsPkg::ctrlJump]),
        .a(cmpAD), .b(cmpBD), .pcSrc(pcSrcD)
    );

    // decode/execute
    always_ff @(posedge clk) begin
        if (!rstN || flushE) begin
            ctrlE   <= '0;
            opcodeE <= '0;
        end else begin
            ctrlE   <= mainControl;
            opcodeE <= instrD[31:26];
        end
    end

    always_ff @(posedge clk) begin
        aluOpE   <= aluControl;
        rd1E     <= rd1D;
        rd2E     <= rd2D;
        rsE      <= rsD;
        rtE      <= rtD;
        rdE      <= instrD[15:11];
        shamtE   <= instrD[10:6];
        immE     <= immD;
        pcPlus4E <= pcPlus4D;
    end

    // execute
    always_comb begin
        case (forwardAE)
            mipsPkg::fwdMem: fwdAE = aluOutM;
            mipsPkg::fwdWb:  fwdAE = resultW;
            default:         fwdAE = rd1E;
        endcase
        case (forwardBE)
            mipsPkg::fwdMem: fwdBE = aluOutM;
            mipsPkg::fwdWb:  fwdBE = resultW;
            default:         fwdBE = rd2E;
        endcase
        case (ctrlE[mipsPkg::ctrlRegDst +: 2])
            2'd1:    writeRegE = rdE;
            2'd2:    writeRegE = 5'd31;
            default: writeRegE = rtE;
        endcase
    end

    // link address is pc+4 plus zero
    assign srcAE = ctrlE[mipsPkg::ctrlAluSrcPc] ? pcPlus4E : fwdAE;
    assign srcBE = ctrlE[mipsPkg::ctrlAluSrcPc] ? '0 :
                   ctrlE[mipsPkg::ctrlAluSrcImm] ? immE : fwdBE;

    alu execAlu (.a(srcAE), .b(srcBE), .shamt(shamtE), .aluControl(aluOpE), .result(aluOutE));

    // execute/memory
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrlM   <= '0;
            opcodeM <= '0;
        end else begin
            ctrlM   <= ctrlE;
            opcodeM <= opcodeE;
        end
    end

    always_ff @(posedge clk) begin
        aluOutM    <= aluOutE;
        writeDataM <= fwdBE;
        writeRegM  <= writeRegE;
    end

    memAlign align (
        .clk(clk), .opcode(opcodeM), .addr(aluOutM), .writeData(writeDataM),
        .readData(memReadData), .memEn(memEn), .byteEn(memByteEn), .alignedAddr(memAddr),
        .alignedWriteData(memWriteData), .loadData(loadDataM)
    );

    // memory/writeback
    always_ff @(posedge clk) begin
        if (!rstN)
            ctrlW <= '0;
        else
            ctrlW <= ctrlM;
    end

    always_ff @(posedge clk) begin
        aluOutW   <= aluOutM;
        readDataW <= loadDataM;
        writeRegW <= writeRegM;
    end

    assign resultW = ctrlW[mipsPkg::ctrlMemToReg] ? readDataW : aluOutW;

    assign regWriteE = ctrlE[mipsPkg::ctrlRegWrite];
    assign regWriteM = ctrlM[mipsPkg::ctrlRegWrite];
    assign regWriteW = ctrlW[mipsPkg::ctrlRegWrite];
    assign memToRegE = ctrlE[mipsPkg::ctrlMemRead];  // load in flight
    assign memToRegM = ctrlM[mipsPkg::ctrlMemRead];

    // held decode must not also issue into execute
    assert property (@(posedge clk) disable iff (!rstN) stallD |-> (stallF && flushE));

endmodule

`default_nettype wire

//--- src/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLb      = 6'h20;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opLbu     = 6'h24;
    localparam logic [5:0] opSb      = 6'h28;
    localparam logic [5:0] opSw      = 6'h2b;

    // special function field
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSra  = 6'h03;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    localparam logic [3:0] aluAdd  = 4'd0;
    localparam logic [3:0] aluSub  = 4'd1;
    localparam logic [3:0] aluAnd  = 4'd2;
    localparam logic [3:0] aluOr   = 4'd3;
    localparam logic [3:0] aluXor  = 4'd4;
    localparam logic [3:0] aluNor  = 4'd5;
    localparam logic [3:0] aluSlt  = 4'd6;
    localparam logic [3:0] aluSltu = 4'd7;
    localparam logic [3:0] aluSll  = 4'd8;
    localparam logic [3:0] aluSrl  = 4'd9;
    localparam logic [3:0] aluSra  = 4'd10;
    localparam logic [3:0] aluLui  = 4'd11;

    // decode control word, bit positions (regDst is two bits wide)
    localparam int ctrlWidth     = 10;
    localparam int ctrlRegWrite  = 0;
    localparam int ctrlRegDst    = 1;  // 0 rt, 1 rd, 2 r31
    localparam int ctrlAluSrcPc  = 3;
    localparam int ctrlAluSrcImm = 4;
    localparam int ctrlMemToReg  = 5;
    localparam int ctrlBranch    = 6;
    localparam int ctrlJump      = 7;
    localparam int ctrlZeroExt   = 8;
    localparam int ctrlMemRead   = 9;

    // hazard word, forward fields are two bits wide
    localparam int hazWidth     = 9;
    localparam int hazForwardA  = 0;
    localparam int hazForwardB  = 2;
    localparam int hazStallF    = 4;
    localparam int hazStallD    = 5;
    localparam int hazFlushE    = 6;
    localparam int hazForwardAD = 7;
    localparam int hazForwardBD = 8;

    localparam logic [1:0] fwdNone = 2'd0;
    localparam logic [1:0] fwdWb   = 2'd1;
    localparam logic [1:0] fwdMem  = 2'd2;

    localparam logic [1:0] pcPlus4  = 2'd0;
    localparam logic [1:0] pcBranch = 2'd1;
    localparam logic [1:0] pcJump   = 2'd2;
    localparam logic [1:0] pcReg    = 2'd3;

endpackage

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  logic                             clk,
    input  logic                             writeEn,
    input  logic [mipsPkg::regAddrWidth-1:0] readAddr1, readAddr2, writeAddr,
    input  logic [mipsPkg::dataWidth-1:0]    writeData,
    output logic [mipsPkg::dataWidth-1:0]    readData1, readData2
);

    logic [mipsPkg::dataWidth-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (writeEn)
            regs[writeAddr] <= writeData;
    end

    // write-through so writeback and decode can share a cycle
    assign readData1 = (readAddr1 == 5'd0) ? '0 :
                       (writeEn && writeAddr == readAddr1) ? writeData : regs[readAddr1];
    assign readData2 = (readAddr2 == 5'd0) ? '0 :
                       (writeEn && writeAddr == readAddr2) ? writeData : regs[readAddr2];

    assert property (@(posedge clk) (readAddr1 == 5'd0) |-> (readData1 == '0));
    assert property (@(posedge clk) (readAddr2 == 5'd0) |-> (readData2 == '0));

endmodule

`default_nettype wire
